//--- verif/dcache_stimulus.txt
# op address word, all hex; one request per line.
# R: word is the expected load. W: word is the store data. H: halt, address and word unused.
R 00000100 5A5A0100
R 00000100 5A5A0100
W 00000104 DEADBEEF
R 00000104 DEADBEEF
R 00000100 5A5A0100
# three blocks in set 1 force evictions of dirty frames.
W 00000208 11110001
W 00000408 22220002
R 0000060C 5A5A060C
R 00000208 11110001
R 00000408 22220002
# traffic across all eight sets.
W 00000800 A0000000
W 0000080C A1000001
W 00000810 A2000002
R 00000818 5A5A0818
W 0000081C A3000003
W 00000820 A4000004
R 00000824 5A5A0824
W 0000082C A5000005
W 00000830 A6000006
W 0000083C A7000007
R 00001000 5A5A1000
R 00000104 DEADBEEF
R 00000800 A0000000
R 0000080C A1000001
R 00000810 A2000002
R 0000081C A3000003
R 00000818 5A5A0818
W 00001808 B1000001
R 0000080C A1000001
R 00001808 B1000001
R 0000082C A5000005
R 00000834 5A5A0834
R 0000083C A7000007
R 00000838 5A5A0838
W 00000824 A4000024
R 00000820 A4000004
R 00000824 A4000024
R 00000208 11110001
H 00000000 00000000

//--- tb.f
design/dcache_pkg.sv
design/cache_sets.sv
design/dcache_fsm.sv
design/dcache.sv
verif/main_memory_model.sv
verif/dcache_tb.sv

//--- verif/dcache_tb.sv
`default_nettype none

module dcache_tb;
        timeunit 1ns;
        timeprecision 100ps;
        import dcache_pkg::*;

        localparam int SEED = 33;
        localparam int CYCLES_PER_LINE = 40;
        localparam int CYCLES_BASE = 2000;
        localparam int IMAGE_WORDS = 4096;

        logic     CLK;
        logic     nRST;
        cpu_req_t cpu_req;
        cpu_rsp_t cpu_rsp;
        mem_req_t mem_req;
        mem_rsp_t mem_rsp;
        word_t    peek_addr;
        word_t    peek_data;

        byte      stim_op [$];
        word_t    stim_addr [$];
        word_t    stim_word [$];
        int       cycle_limit = 0;
        int       cycle_count = 0;

        // ~~~~~~~~~~~~~~~~~~~~
        // reference model
        word_t            image [IMAGE_WORDS];
        logic             ref_valid [WAYS][SETS];
        logic [TAG_W-1:0] ref_tag [WAYS][SETS];
        logic             ref_lru [SETS];
        word_t            ref_hits;
        word_t            written_addr [$];

        dcache i_dcache (
                .CLK     (CLK),
                .nRST    (nRST),
                .cpu_req (cpu_req),
                .cpu_rsp (cpu_rsp),
                .mem_req (mem_req),
                .mem_rsp (mem_rsp)
        );

        main_memory_model i_memory (
                .CLK       (CLK),
                .nRST      (nRST),
                .mem_req   (mem_req),
                .mem_rsp   (mem_rsp),
                .peek_addr (peek_addr),
                .peek_data (peek_data)
        );

        initial begin
                CLK = 1'b0;
                forever #2 CLK = ~CLK;
        end

        always @(posedge CLK) begin
                cycle_count <= cycle_count + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                        abort_run("The cache stalled and did not respond before the cycle limit.");
                end
        end

        task automatic fail_and_stop();
                $display("Test FAILED");
                $fatal(1, "simulation stopped on the first error");
        endtask

        task automatic abort_run(input string reason);
                $display("%s", reason);
                fail_and_stop();
        endtask

        task automatic check_load(input string name, input word_t expected, input word_t actual);
                if (actual !== expected) begin
                        $display("[FAIL] %s load: expected %h, actual %h", name, expected, actual);
                        fail_and_stop();
                end
        endtask

        task automatic check_mem(input string name, input word_t expected, input word_t actual);
                if (actual !== expected) begin
                        $display("[FAIL] %s memory: expected %h, actual %h", name, expected, actual);
                        fail_and_stop();
                end
        endtask

        function automatic int image_index(input word_t addr);
                return int'(addr[13:2]);
        endfunction

        task automatic reset_model();
                for (int i = 0; i < IMAGE_WORDS; i++) begin
                        image[i] = (word_t'(i) << 2) ^ 32'h5A5A_0000;
                end
                for (int s = 0; s < SETS; s++) begin
                        ref_valid[0][s] = 1'b0;
                        ref_valid[1][s] = 1'b0;
                        ref_lru[s] = 1'b0;
                end
                ref_hits = '0;
        endtask

        // a miss counts down, then its final hit counts up again.
        task automatic model_access(input word_t addr);
                dcache_addr_t a;
                logic         hit;
                logic         way;
                a = addr;
                hit = 1'b0;
                way = 1'b0;
                for (int w = 0; w < WAYS; w++) begin
                        if (ref_valid[w][a.idx] && ref_tag[w][a.idx] == a.tag) begin
                                hit = 1'b1;
                                way = 1'(w);
                        end
                end
                if (!hit) begin
                        way = ref_lru[a.idx];
                        ref_valid[way][a.idx] = 1'b1;
                        ref_tag[way][a.idx] = a.tag;
                        ref_hits = ref_hits - 1'b1;
                end
                ref_hits = ref_hits + 1'b1;
                ref_lru[a.idx] = !way;
        endtask

        task automatic load_stimulus();
                int    fd;
                int    n;
                int    c;
                logic  done;
                byte   op;
                word_t a;
                word_t d;
                fd = $fopen("verif/dcache_stimulus.txt", "r");
                if (fd == 0) begin
                        abort_run("Could not open the stimulus file verif/dcache_stimulus.txt.");
                end
                done = 1'b0;
                while (!done) begin
                        n = $fscanf(fd, " %c", op);
                        if (n != 1) begin
                                done = 1'b1;
                        end else if (op == "#") begin
                                c = $fgetc(fd); // rest of a comment line.
                                while (c != "\n" && c != -1) begin
                                        c = $fgetc(fd);
                                end
                        end else begin
                                n = $fscanf(fd, "%h %h", a, d);
                                if (n != 2) begin
                                        abort_run($sformatf("Stimulus line for op %c could not be parsed.",
                                                            op));
                                end
                                stim_op.push_back(op);
                                stim_addr.push_back(a);
                                stim_word.push_back(d);
                        end
                end
                $fclose(fd);
        endtask

        // called on a falling edge; returns on the falling edge after the hit.
        task automatic run_request(input int n);
                string    name;
                cpu_req_t req;
                word_t    load;
                name = $sformatf("request %0d (%c %h)", n, stim_op[n], stim_addr[n]);
                req = '0;
                req.ren = (stim_op[n] == "R");
                req.wen = (stim_op[n] == "W");
                req.addr = stim_addr[n];
                req.store = req.wen ? stim_word[n] : '0;
                cpu_req = req;
                #1;
                while (!cpu_rsp.hit) begin
                        @(negedge CLK);
                        #1;
                end
                load = cpu_rsp.load;
                @(negedge CLK);
                cpu_req = '0;
                model_access(stim_addr[n]);
                if (req.ren) begin
                        check_load(name, image[image_index(stim_addr[n])], load);
                        check_load(name, stim_word[n], load);
                end else begin
                        image[image_index(stim_addr[n])] = stim_word[n];
                        written_addr.push_back(stim_addr[n]);
                end
        endtask

        task automatic halt_and_verify();
                cpu_req = '0;
                cpu_req.halt = 1'b1;
                while (!cpu_rsp.flushed) begin
                        @(negedge CLK);
                end
                foreach (written_addr[i]) begin
                        peek_addr = written_addr[i];
                        #1;
                        check_mem($sformatf("flushed word %h", written_addr[i]),
                                  image[image_index(written_addr[i])], peek_data);
                end
                peek_addr = HIT_COUNT_ADDR;
                #1;
                check_mem("hit counter", ref_hits, peek_data);
        endtask

        initial begin
                bit halted;
                cpu_req = '0;
                peek_addr = '0;
                nRST = 1'b0;
                halted = 1'b0;
                void'($urandom(SEED));
                reset_model();
                load_stimulus();
                cycle_limit = CYCLES_PER_LINE * stim_op.size() + CYCLES_BASE;
                repeat (2) @(negedge CLK);
                nRST = 1'b1;
                @(negedge CLK);
                for (int n = 0; n < stim_op.size() && !halted; n++) begin
                        if (stim_op[n] == "H") begin
                                halt_and_verify();
                                halted = 1'b1;
                        end else begin
                                run_request(n);
                                repeat ($urandom_range(3, 0)) @(negedge CLK);
                        end
                end
                if (!halted) begin
                        abort_run("The stimulus file ended without a halt request.");
                end else begin
                        $display("Test OK");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- verif/main_memory_model.sv
`default_nettype none

module main_memory_model (
        input  logic                 CLK,
        input  logic                 nRST,
        input  dcache_pkg::mem_req_t mem_req,
        output dcache_pkg::mem_rsp_t mem_rsp,
        input  dcache_pkg::word_t    peek_addr,
        output dcache_pkg::word_t    peek_data
);
        timeunit 1ns;
        timeprecision 100ps;
        import dcache_pkg::*;

        localparam int WAIT_CYCLES = 2;
        localparam int DEPTH = 4096;

        word_t      mem [DEPTH];
        logic [1:0] wait_cnt;
        logic       busy;
        logic       ready;

        function automatic int word_index(input word_t addr);
                return int'(addr[13:2]); // byte address to word slot.
        endfunction

        initial begin
                for (int i = 0; i < DEPTH; i++) begin
                        mem[i] = (word_t'(i) << 2) ^ 32'h5A5A_0000;
                end
        end

        assign busy = mem_req.ren || mem_req.wen;
        assign ready = busy && (wait_cnt == 2'(WAIT_CYCLES)); // access completes in this cycle.
        assign mem_rsp.dwait = busy && !ready;
        assign mem_rsp.load = mem[word_index(mem_req.addr)];
        assign peek_data = mem[word_index(peek_addr)];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        wait_cnt <= '0;
                end else if (ready) begin
                        wait_cnt <= '0;
                end else if (busy) begin
                        wait_cnt <= wait_cnt + 1'b1;
                end
        end

        always @(posedge CLK) begin
                if (ready && mem_req.wen) begin
                        mem[word_index(mem_req.addr)] <= mem_req.store;
                end
        end

endmodule

`default_nettype wire

//--- design/dcache.sv
`default_nettype none

module dcache (
        input  logic                 CLK,
        input  logic                 nRST,
        input  dcache_pkg::cpu_req_t cpu_req,
        output dcache_pkg::cpu_rsp_t cpu_rsp,
        output dcache_pkg::mem_req_t mem_req,
        input  dcache_pkg::mem_rsp_t mem_rsp
);
        import dcache_pkg::*;

        dcache_addr_t             lookup_addr;
        logic [IDX_W-1:0]         flush_idx;
        frame_op_t                frame_op;
        logic                     touch;
        lookup_t                  lookup;
        frame_t [WAYS-1:0]        flush_frames;

        // ~~~~~~~~~~~~~~~~~~~~
        // frame storage
        cache_sets i_cache_sets (
                .CLK          (CLK),
                .nRST         (nRST),
                .addr         (lookup_addr),
                .flush_idx    (flush_idx),
                .frame_op     (frame_op),
                .touch        (touch),
                .lookup       (lookup),
                .flush_frames (flush_frames)
        );

        // ~~~~~~~~~~~~~~~~~~~~
        // miss, write-back and flush control
        dcache_fsm i_dcache_fsm (
                .CLK          (CLK),
                .nRST         (nRST),
                .cpu_req      (cpu_req),
                .cpu_rsp      (cpu_rsp),
                .mem_req      (mem_req),
                .mem_rsp      (mem_rsp),
                .lookup       (lookup),
                .flush_frames (flush_frames),
                .lookup_addr  (lookup_addr),
                .flush_idx    (flush_idx),
                .frame_op     (frame_op),
                .touch        (touch)
        );

endmodule

`default_nettype wire

//--- design/dcache_fsm.sv
`default_nettype none

module dcache_fsm (
        input  logic                                     CLK,
        input  logic                                     nRST,
        input  dcache_pkg::cpu_req_t                     cpu_req,
        output dcache_pkg::cpu_rsp_t                     cpu_rsp,
        output dcache_pkg::mem_req_t                     mem_req,
        input  dcache_pkg::mem_rsp_t                     mem_rsp,
        input  dcache_pkg::lookup_t                      lookup,
        input  dcache_pkg::frame_t [dcache_pkg::WAYS-1:0] flush_frames,
        output dcache_pkg::dcache_addr_t                 lookup_addr,
        output logic [dcache_pkg::IDX_W-1:0]             flush_idx,
        output dcache_pkg::frame_op_t                    frame_op,
        output logic                                     touch
);
        import dcache_pkg::*;

        typedef enum logic [3:0] {
                S_LOOKUP,
                S_WB0,
                S_WB1,
                S_FILL0,
                S_FILL1,
                S_FLUSH_SCAN,
                S_FLUSH_WB0,
                S_FLUSH_WB1,
                S_COUNT,
                S_FLUSHED
        } state_e;

        state_e           state_q, state_d;
        logic             victim_way_q, victim_way_d;
        logic [TAG_W-1:0] victim_tag_q, victim_tag_d;
        word_t            hit_count_q, hit_count_d;
        logic [IDX_W-1:0] flush_set_q, flush_set_d;
        logic             flush_way_q, flush_way_d;

        dcache_addr_t     req_addr;
        logic             req_valid;
        logic             mem_done;
        logic             in_flush;
        logic             word_sel;
        logic             wb_way;
        frame_t           wb_frame;
        logic [TAG_W-1:0] wb_tag;

        assign req_addr = cpu_req.addr;
        assign req_valid = (cpu_req.ren || cpu_req.wen) && !cpu_req.halt;
        assign mem_done = !mem_rsp.dwait;
        assign lookup_addr = req_addr;

        assign in_flush = state_q inside {S_FLUSH_SCAN, S_FLUSH_WB0, S_FLUSH_WB1};
        assign word_sel = state_q inside {S_WB1, S_FILL1, S_FLUSH_WB1}; // second word of the block.
        assign flush_idx = in_flush ? flush_set_q : req_addr.idx;

        // a miss writes back the way latched at its start, a flush the way under scan.
        assign wb_way = in_flush ? flush_way_q : victim_way_q;
        assign wb_frame = flush_frames[wb_way];
        assign wb_tag = in_flush ? wb_frame.tag : victim_tag_q;

        // ~~~~~~~~~~~~~~~~~~~~
        // next state and outputs
        always_comb begin
                state_d = state_q;
                victim_way_d = victim_way_q;
                victim_tag_d = victim_tag_q;
                hit_count_d = hit_count_q;
                flush_set_d = flush_set_q;
                flush_way_d = flush_way_q;

                cpu_rsp.hit = 1'b0;
                cpu_rsp.load = lookup.victim_data;
                cpu_rsp.flushed = (state_q == S_FLUSHED);
                mem_req = '0;
                touch = 1'b0;

                frame_op.op = OP_NONE;
                frame_op.way = wb_way;
                frame_op.idx = flush_idx;
                frame_op.blkoff = word_sel;
                frame_op.tag = req_addr.tag;
                frame_op.data = mem_rsp.load;

                case (state_q)
                S_LOOKUP: begin
                        if (cpu_req.halt) begin
                                state_d = S_FLUSH_SCAN;
                        end else if (req_valid && lookup.hit) begin
                                cpu_rsp.hit = 1'b1;
                                touch = 1'b1;
                                hit_count_d = hit_count_q + 1'b1;
                                if (cpu_req.wen) begin
                                        frame_op.op = OP_STORE;
                                        frame_op.way = lookup.hit_way;
                                        frame_op.blkoff = req_addr.blkoff;
                                        frame_op.data = cpu_req.store;
                                end
                        end else if (req_valid) begin
                                victim_way_d = lookup.victim_way; // fixed for the whole miss.
                                victim_tag_d = lookup.victim_tag;
                                hit_count_d = hit_count_q - 1'b1;
                                state_d = lookup.victim_dirty ? S_WB0 : S_FILL0;
                        end
                end
                S_WB0, S_WB1, S_FLUSH_WB0, S_FLUSH_WB1: begin
                        mem_req.wen = 1'b1;
                        mem_req.addr = {wb_tag, flush_idx, word_sel, 2'b00};
                        mem_req.store = wb_frame.data[word_sel];
                        if (mem_done) begin
                                case (state_q)
                                S_WB0: begin
                                        state_d = S_WB1;
                                end
                                S_WB1: begin
                                        frame_op.op = OP_CLEAN;
                                        state_d = S_FILL0;
                                end
                                S_FLUSH_WB0: begin
                                        state_d = S_FLUSH_WB1;
                                end
                                default: begin
                                        frame_op.op = OP_INVAL; // scan then finds it clean.
                                        state_d = S_FLUSH_SCAN;
                                end
                                endcase
                        end
                end
                S_FILL0, S_FILL1: begin
                        mem_req.ren = 1'b1;
                        mem_req.addr = {req_addr.tag, req_addr.idx, word_sel, 2'b00};
                        if (mem_done) begin
                                frame_op.op = word_sel ? OP_VALIDATE : OP_FILL;
                                state_d = word_sel ? S_LOOKUP : S_FILL1;
                        end
                end
                S_FLUSH_SCAN: begin
                        if (wb_frame.dirty) begin
                                state_d = S_FLUSH_WB0;
                        end else if (flush_set_q == IDX_W'(SETS - 1) && flush_way_q) begin
                                state_d = S_COUNT;
                        end else begin
                                flush_way_d = !flush_way_q;
                                if (flush_way_q) begin
                                        flush_set_d = flush_set_q + 1'b1;
                                end
                        end
                end
                S_COUNT: begin
                        mem_req.wen = 1'b1;
                        mem_req.addr = HIT_COUNT_ADDR;
                        mem_req.store = hit_count_q;
                        if (mem_done) begin
                                state_d = S_FLUSHED;
                        end
                end
                S_FLUSHED: begin
                end
                default: begin
                        state_d = S_LOOKUP;
                end
                endcase
        end

        // ~~~~~~~~~~~~~~~~~~~~
        // registers
        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state_q <= S_LOOKUP;
                        victim_way_q <= 1'b0;
                        hit_count_q <= '0;
                        flush_set_q <= '0;
                        flush_way_q <= 1'b0;
                end else begin
                        state_q <= state_d;
                        victim_way_q <= victim_way_d;
                        hit_count_q <= hit_count_d;
                        flush_set_q <= flush_set_d;
                        flush_way_q <= flush_way_d;
                end
        end

        always_ff @(posedge CLK) begin
                victim_tag_q <= victim_tag_d;
        end

        a_mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
                !(mem_req.ren && mem_req.wen));

        // a stalled access must look the same to memory until it completes.
        a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
                (mem_req.ren || mem_req.wen) && mem_rsp.dwait |=> $stable(mem_req));

endmodule

`default_nettype wire

//--- design/cache_sets.sv
`default_nettype none

module cache_sets (
        input  logic                                     CLK,
        input  logic                                     nRST,
        input  dcache_pkg::dcache_addr_t                 addr,
        input  logic [dcache_pkg::IDX_W-1:0]             flush_idx,
        input  dcache_pkg::frame_op_t                    frame_op,
        input  logic                                     touch,
        output dcache_pkg::lookup_t                      lookup,
        output dcache_pkg::frame_t [dcache_pkg::WAYS-1:0] flush_frames
);
        import dcache_pkg::*;

        logic [SETS-1:0]         valid_q [WAYS];
        logic [SETS-1:0]         dirty_q [WAYS];
        logic [TAG_W-1:0]        tag_mem [WAYS][SETS];
        word_t [BLOCK_WORDS-1:0] data_mem [WAYS][SETS];
        logic [SETS-1:0]         lru_q; // per set, the way to evict next.

        frame_t                  set_frames [WAYS];
        logic [WAYS-1:0]         way_hit;
        logic                    sel_way;

        function automatic frame_t read_frame(input logic way, input logic [IDX_W-1:0] idx);
                frame_t f;
                f.valid = valid_q[way][idx];
                f.dirty = dirty_q[way][idx];
                f.tag = tag_mem[way][idx];
                f.data = data_mem[way][idx];
                return f;
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~
        // tag compare and victim selection
        always_comb begin
                for (int w = 0; w < WAYS; w++) begin
                        set_frames[w] = read_frame(1'(w), addr.idx);
                        flush_frames[w] = read_frame(1'(w), flush_idx);
                        way_hit[w] = set_frames[w].valid && (set_frames[w].tag == addr.tag);
                end
                lookup.hit = |way_hit;
                lookup.hit_way = way_hit[1];
                lookup.victim_way = lru_q[addr.idx];
                lookup.victim_dirty = set_frames[lookup.victim_way].dirty;
                lookup.victim_tag = set_frames[lookup.victim_way].tag;
                sel_way = lookup.hit ? lookup.hit_way : lookup.victim_way;
                lookup.victim_data = set_frames[sel_way].data[addr.blkoff];
        end

        // ~~~~~~~~~~~~~~~~~~~~
        // frame state and replacement
        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        for (int w = 0; w < WAYS; w++) begin
                                valid_q[w] <= '0;
                                dirty_q[w] <= '0;
                        end
                        lru_q <= '0;
                end else begin
                        case (frame_op.op)
                        OP_STORE: begin
                                dirty_q[frame_op.way][frame_op.idx] <= 1'b1;
                        end
                        OP_FILL: begin
                                valid_q[frame_op.way][frame_op.idx] <= 1'b0; // half a block is no frame yet.
                                dirty_q[frame_op.way][frame_op.idx] <= 1'b0;
                        end
                        OP_VALIDATE: begin
                                valid_q[frame_op.way][frame_op.idx] <= 1'b1;
                        end
                        OP_CLEAN: begin
                                dirty_q[frame_op.way][frame_op.idx] <= 1'b0;
                        end
                        OP_INVAL: begin
                                valid_q[frame_op.way][frame_op.idx] <= 1'b0;
                                dirty_q[frame_op.way][frame_op.idx] <= 1'b0;
                        end
                        default: begin
                        end
                        endcase
                        if (touch) begin
                                lru_q[addr.idx] <= !lookup.hit_way; // the other way is now the older one.
                        end
                end
        end

        always_ff @(posedge CLK) begin
                if (frame_op.op inside {OP_STORE, OP_FILL, OP_VALIDATE}) begin
                        data_mem[frame_op.way][frame_op.idx][frame_op.blkoff] <= frame_op.data;
                end
                if (frame_op.op == OP_FILL) begin
                        tag_mem[frame_op.way][frame_op.idx] <= frame_op.tag;
                end
        end

        // a block may live in one way of its set only.
        a_single_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
                way_hit != 2'b11);

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

        // ~~~~~~~~~~~~~~~~~~~~
        // geometry
        localparam int WORD_W = 32;
        localparam int TAG_W = 26;
        localparam int IDX_W = 3;
        localparam int SETS = 8;
        localparam int WAYS = 2;
        localparam int BLOCK_WORDS = 2;
        localparam logic [WORD_W-1:0] HIT_COUNT_ADDR = 32'h0000_3100; // counter lands here on halt.

        typedef logic [WORD_W-1:0] word_t;

        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] idx;
                logic             blkoff;
                logic [1:0]       bytoff;
        } dcache_addr_t;

        typedef struct packed {
                logic                     valid;
                logic                     dirty;
                logic [TAG_W-1:0]         tag;
                word_t [BLOCK_WORDS-1:0]  data;
        } frame_t;

        // ~~~~~~~~~~~~~~~~~~~~
        // port bundles
        typedef struct packed {
                logic  ren;
                logic  wen;
                logic  halt;
                word_t addr;
                word_t store;
        } cpu_req_t;

        typedef struct packed {
                logic  hit;
                word_t load;
                logic  flushed;
        } cpu_rsp_t;

        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t store;
        } mem_req_t;

        typedef struct packed {
                logic  dwait; // memory is still busy with the current access.
                word_t load;
        } mem_rsp_t;

        // ~~~~~~~~~~~~~~~~~~~~
        // between the controller and the set storage
        typedef struct packed {
                logic             hit;
                logic             hit_way;
                logic             victim_way;
                logic             victim_dirty;
                logic [TAG_W-1:0] victim_tag;
                word_t            victim_data; // word of the hit way, or of the victim on a miss.
        } lookup_t;

        typedef enum logic [2:0] {
                OP_NONE,
                OP_STORE,
                OP_FILL,
                OP_VALIDATE,
                OP_CLEAN,
                OP_INVAL
        } frame_op_e;

        typedef struct packed {
                frame_op_e        op;
                logic             way;
                logic [IDX_W-1:0] idx;
                logic             blkoff;
                logic [TAG_W-1:0] tag;
                word_t            data;
        } frame_op_t;

endpackage

`default_nettype wire
